/* files.f */
source/link_pkg.sv
source/circular_ptr.sv
source/rr_static_hub.sv
source/echo_node.sv
source/rr_echo_top.sv
testbench/rr_echo_properties.sv
testbench/rr_echo_tb.sv

/* Bender.yml */
package:
  name: rr_echo

sources:
  - source/link_pkg.sv
  - source/circular_ptr.sv
  - source/rr_static_hub.sv
  - source/echo_node.sv
  - source/rr_echo_top.sv
  - target: test
    files:
      - testbench/rr_echo_properties.sv
      - testbench/rr_echo_tb.sv

/* testbench/rr_echo_tb.sv */
module rr_echo_tb;

  localparam int NC         = link_pkg::NUM_CLIENTS_DEF;
  localparam int DW         = link_pkg::DATA_WIDTH_DEF;
  localparam int SC         = link_pkg::SERVICE_CYCLES_DEF;
  localparam int HELD       = 2;  // Client that starts late
  localparam int GAP_CYCLES = 20;
  localparam int MAX_STALL  = 6;
  localparam int PER_PHASE  = 8;  // Requests per client and phase
  localparam int TOTAL_REQ  = 3 * NC * PER_PHASE;
  localparam int TIMEOUT    = TOTAL_REQ * (SC + 3 + MAX_STALL) + GAP_CYCLES + 200;

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic [NC-1:0]         req_v;
  logic [NC-1:0][DW-1:0] req_data;
  logic [NC-1:0]         req_yumi;
  logic [NC-1:0]         rsp_v;
  logic [NC-1:0][DW-1:0] rsp_data;
  logic [NC-1:0]         rsp_yumi;
  logic [NC-1:0]         req_xfer_s = '0;
  logic [NC-1:0]         rsp_v_s    = '0;
  logic [NC-1:0]         rsp_xfer_s = '0;
  logic [NC-1:0]         held_v;
  logic [DW-1:0]         held_data;
  logic                  hold_late = 1'b0;
  logic                  bp_mode   = 1'b0;
  bit                    head_seen;
  int                    quota [NC];
  int                    issued [NC];
  int                    cycle;
  int                    stall_left;
  int                    accept_count;
  int                    reply_count;
  int                    err_count;
  int                    exp_client_q [$];
  logic [DW-1:0]         exp_data_q [$];
  int                    exp_cycle_q [$];

  rr_echo_top dut_i (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .req_v_i    (req_v),
    .req_data_i (req_data),
    .req_yumi_o (req_yumi),
    .rsp_v_o    (rsp_v),
    .rsp_data_o (rsp_data),
    .rsp_yumi_i (rsp_yumi)
  );

  bind rr_echo_top rr_echo_properties #(
    .NUM_CLIENTS (NUM_CLIENTS),
    .DATA_WIDTH  (DATA_WIDTH)
  ) props_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_v_i     (req_v_i),
    .req_data_i  (req_data_i),
    .req_yumi_o  (req_yumi_o),
    .rsp_v_o     (rsp_v_o)
  );

  always #20 clk = ~clk;

  function automatic logic [DW-1:0] echo_ref(input logic [DW-1:0] word);
    return word ^ DW'(link_pkg::REPLY_KEY);
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    err_count++;
  endtask

  task automatic print_counts();
    $display("Requests %0d, replies %0d, errors %0d", accept_count, reply_count, err_count);
  endtask

  task automatic run_phase(input bit late_client, input bit stalls);
    int target;
    target = accept_count + NC * PER_PHASE;
    @(negedge clk);
    hold_late <= late_client;
    bp_mode   <= stalls;
    for (int c = 0; c < NC; c++)
      quota[c] <= quota[c] + PER_PHASE;
    repeat (GAP_CYCLES) @(negedge clk);
    hold_late <= 1'b0;
    while (accept_count < target || exp_client_q.size() != 0)
      @(posedge clk);
  endtask

  // ########################################
  // Stimulus
  // ########################################

  always @(posedge clk)
  begin
    for (int c = 0; c < NC; c++)
    begin
      if (!req_v[c] || req_xfer_s[c])
      begin
        if (arst_n && issued[c] < quota[c] && !(hold_late && c == HELD))
        begin
          req_v[c]    <= 1'b1;
          req_data[c] <= DW'($urandom);
          issued[c]   = issued[c] + 1;
        end
        else
          req_v[c] <= 1'b0;
      end
    end
    if (rsp_xfer_s != '0)
    begin
      rsp_yumi   <= '0;
      stall_left = bp_mode ? $urandom_range(MAX_STALL, 0) : 0;  // Next stretch
    end
    else if (stall_left > 0 && rsp_v_s != '0)
    begin
      rsp_yumi   <= '0;
      stall_left = stall_left - 1;
    end
    else
      rsp_yumi <= rsp_v_s;
  end

  // ########################################
  // Compare
  // ########################################

  always @(negedge clk)
  begin
    int exp_cl;
    int slot;
    req_xfer_s = req_v & req_yumi;
    rsp_v_s    = rsp_v;
    rsp_xfer_s = rsp_v & rsp_yumi;
    if ((!arst_n || cycle == 0) && (req_yumi !== '0 || rsp_v !== '0))
      report_error($sformatf("strobes %b / %b not idle around reset", req_yumi, rsp_v));
    if (arst_n && rsp_v != '0)
    begin
      if (!$onehot(rsp_v))
        report_error($sformatf("reply valid %b is not one-hot", rsp_v));
      if (exp_client_q.size() == 0)
        report_error("reply without any outstanding request");
      else
      begin
        exp_cl = exp_client_q[0];
        if (!head_seen)
        begin
          if (rsp_v[exp_cl] !== 1'b1)
            report_error($sformatf("reply on %b, expected client %0d", rsp_v, exp_cl));
          if (rsp_data[exp_cl] !== echo_ref(exp_data_q[0]))
            report_error($sformatf("reply %h, expected %h", rsp_data[exp_cl],
                                   echo_ref(exp_data_q[0])));
          if (cycle - exp_cycle_q[0] != SC + 1)
            report_error($sformatf("reply after %0d cycles, expected %0d",
                                   cycle - exp_cycle_q[0], SC + 1));
          head_seen = 1'b1;
          held_v    = rsp_v;
          held_data = rsp_data[exp_cl];
        end
        else if (rsp_v !== held_v || rsp_data[exp_cl] !== held_data)
          report_error("reply changed while it was stalled");
        if ((rsp_v & rsp_yumi) != '0)
        begin
          void'(exp_client_q.pop_front());
          void'(exp_data_q.pop_front());
          void'(exp_cycle_q.pop_front());
          head_seen = 1'b0;
          reply_count++;
        end
      end
    end
    else if (head_seen)
    begin
      report_error("reply withdrawn before it was consumed");
      head_seen = 1'b0;
    end
    for (int c = 0; arst_n && c < NC; c++)
    begin
      if (req_yumi[c] && !req_v[c])
        report_error($sformatf("client %0d strobed without valid", c));
      if (req_yumi[c] && req_v[c])
      begin
        slot = accept_count % NC;
        if (c != slot)
          report_error($sformatf("request taken from client %0d, expected %0d", c, slot));
        if (hold_late && slot == HELD)
          report_error("request taken while the rotation waits on the late client");
        if (exp_client_q.size() != 0)
          report_error("request taken while the node still serves another");
        exp_client_q.push_back(c);
        exp_data_q.push_back(req_data[c]);
        exp_cycle_q.push_back(cycle);
        accept_count++;
      end
    end
  end

  // Cycle count and run limit
  always @(posedge clk)
  begin
    if (arst_n)
      cycle <= cycle + 1;
    if (cycle >= TIMEOUT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      print_counts();
      $display("Test FAILED");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'hc5f3_7e78));
    arst_n   = 1'b0;
    req_v    = '0;
    req_data = '0;
    rsp_yumi = '0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    run_phase(1'b0, 1'b0);  // Static order
    run_phase(1'b1, 1'b0);  // Client 2 late
    run_phase(1'b0, 1'b1);  // Reply stalls
    if (reply_count != TOTAL_REQ)
    begin
      $display("Only %0d of %0d replies arrived", reply_count, TOTAL_REQ);
      err_count++;
    end
    print_counts();
    if (err_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* testbench/rr_echo_properties.sv */
module rr_echo_properties
#(
  parameter int NUM_CLIENTS = link_pkg::NUM_CLIENTS_DEF,
  parameter int DATA_WIDTH  = link_pkg::DATA_WIDTH_DEF
)
(
  input logic                                  clk_i,
  input logic                                  arst_n_i,
  input logic [NUM_CLIENTS-1:0]                req_v_i,
  input logic [NUM_CLIENTS-1:0][DATA_WIDTH-1:0] req_data_i,
  input logic [NUM_CLIENTS-1:0]                req_yumi_o,
  input logic [NUM_CLIENTS-1:0]                rsp_v_o
);

  for (genvar c = 0; c < NUM_CLIENTS; c++)
  begin : g_client
    // Request held with stable data until taken
    req_held_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      req_v_i[c] && !req_yumi_o[c] |=> req_v_i[c] && $stable(req_data_i[c]))
      else $error("client %0d dropped or changed its request before it was taken", c);
  end

  rsp_onehot_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(rsp_v_o))
    else $error("more than one client sees a valid reply: %b", rsp_v_o);

  yumi_needs_v_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_yumi_o & ~req_v_i) == '0)
    else $error("request strobe %b without valid %b", req_yumi_o, req_v_i);

endmodule

/* source/rr_echo_top.sv */
module rr_echo_top
#(
  parameter int NUM_CLIENTS    = link_pkg::NUM_CLIENTS_DEF,
  parameter int DATA_WIDTH     = link_pkg::DATA_WIDTH_DEF,
  parameter int SERVICE_CYCLES = link_pkg::SERVICE_CYCLES_DEF
)
(
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,

  input  logic [NUM_CLIENTS-1:0]                req_v_i,
  input  logic [NUM_CLIENTS-1:0][DATA_WIDTH-1:0] req_data_i,
  output logic [NUM_CLIENTS-1:0]                req_yumi_o,

  output logic [NUM_CLIENTS-1:0]                rsp_v_o,
  output logic [NUM_CLIENTS-1:0][DATA_WIDTH-1:0] rsp_data_o,
  input  logic [NUM_CLIENTS-1:0]                rsp_yumi_i
);

  // Shared link between hub and node
  logic                  fwd_v;
  logic [DATA_WIDTH-1:0] fwd_data;
  logic                  fwd_yumi;
  logic                  back_v;
  logic [DATA_WIDTH-1:0] back_data;
  logic                  back_yumi;

  rr_static_hub #(
    .NUM_CLIENTS (NUM_CLIENTS),
    .DATA_WIDTH  (DATA_WIDTH)
  ) hub_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_v_i     (req_v_i),
    .req_data_i  (req_data_i),
    .req_yumi_o  (req_yumi_o),
    .rsp_v_o     (rsp_v_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_yumi_i  (rsp_yumi_i),
    .fwd_v_o     (fwd_v),
    .fwd_data_o  (fwd_data),
    .fwd_yumi_i  (fwd_yumi),
    .back_v_i    (back_v),
    .back_data_i (back_data),
    .back_yumi_o (back_yumi)
  );

  echo_node #(
    .DATA_WIDTH     (DATA_WIDTH),
    .SERVICE_CYCLES (SERVICE_CYCLES)
  ) node_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .fwd_v_i        (fwd_v),
    .fwd_data_i     (fwd_data),
    .fwd_yumi_o     (fwd_yumi),
    .back_v_o       (back_v),
    .back_data_o    (back_data),
    .back_yumi_i    (back_yumi)
  );

endmodule

/* source/echo_node.sv */
module echo_node
#(
  parameter int DATA_WIDTH     = link_pkg::DATA_WIDTH_DEF,
  parameter int SERVICE_CYCLES = link_pkg::SERVICE_CYCLES_DEF
)
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  input  logic                  fwd_v_i,
  input  logic [DATA_WIDTH-1:0] fwd_data_i,
  output logic                  fwd_yumi_o,

  output logic                  back_v_o,
  output logic [DATA_WIDTH-1:0] back_data_o,
  input  logic                  back_yumi_i
);

  localparam int CNT_W = (SERVICE_CYCLES > 1) ? $clog2(SERVICE_CYCLES) : 1;
  localparam logic [CNT_W-1:0]      LAST_CNT = CNT_W'(SERVICE_CYCLES - 1);
  localparam logic [DATA_WIDTH-1:0] KEY      = DATA_WIDTH'(link_pkg::REPLY_KEY);

  link_pkg::node_state_e state_q;
  link_pkg::node_state_e state_d;
  logic [CNT_W-1:0]      cnt_q;
  logic [CNT_W-1:0]      cnt_d;
  logic [DATA_WIDTH-1:0] data_q;
  logic                  accept;

  assign fwd_yumi_o  = (state_q == link_pkg::IDLE) & fwd_v_i;
  assign accept      = fwd_yumi_o;
  assign back_v_o    = (state_q == link_pkg::REPLY);
  assign back_data_o = data_q;

  // ########################################
  // Next state
  // ########################################

  always_comb
  begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      link_pkg::IDLE:
      begin
        if (accept)
        begin
          cnt_d   = '0;
          state_d = (SERVICE_CYCLES == 0) ? link_pkg::REPLY : link_pkg::WAIT;
        end
      end
      link_pkg::WAIT:
      begin
        if (cnt_q == LAST_CNT)
        begin
          state_d = link_pkg::REPLY;
        end
        else
        begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      link_pkg::REPLY:
      begin
        if (back_yumi_i)
        begin
          state_d = link_pkg::IDLE; // Reply taken
        end
      end
      default: state_d = link_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= link_pkg::IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Transformed word, held through WAIT and REPLY
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      data_q <= fwd_data_i ^ KEY;
    end
  end

endmodule

/* source/rr_static_hub.sv */
module rr_static_hub
#(
  parameter int NUM_CLIENTS = link_pkg::NUM_CLIENTS_DEF,
  parameter int DATA_WIDTH  = link_pkg::DATA_WIDTH_DEF
)
(
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,

  // Client request links
  input  logic [NUM_CLIENTS-1:0]                req_v_i,
  input  logic [NUM_CLIENTS-1:0][DATA_WIDTH-1:0] req_data_i,
  output logic [NUM_CLIENTS-1:0]                req_yumi_o,

  // Client response links
  output logic [NUM_CLIENTS-1:0]                rsp_v_o,
  output logic [NUM_CLIENTS-1:0][DATA_WIDTH-1:0] rsp_data_o,
  input  logic [NUM_CLIENTS-1:0]                rsp_yumi_i,

  // Shared link towards the node
  output logic                                  fwd_v_o,
  output logic [DATA_WIDTH-1:0]                 fwd_data_o,
  input  logic                                  fwd_yumi_i,

  // Shared link back from the node
  input  logic                                  back_v_i,
  input  logic [DATA_WIDTH-1:0]                 back_data_i,
  output logic                                  back_yumi_o
);

  localparam int PTR_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

  logic [PTR_W-1:0] conc_ptr;
  logic [PTR_W-1:0] unconc_ptr;
  logic             fwd_xfer;
  logic             back_xfer;

  // ########################################
  // Rotation pointers
  // ########################################

  assign fwd_xfer  = fwd_v_o & fwd_yumi_i;
  assign back_xfer = back_v_i & back_yumi_o;

  circular_ptr #(
    .SLOTS    (NUM_CLIENTS),
    .PTR_W    (PTR_W)
  ) conc_ptr_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .add_i    (fwd_xfer),   // Step after each accepted request
    .ptr_o    (conc_ptr)
  );

  circular_ptr #(
    .SLOTS    (NUM_CLIENTS),
    .PTR_W    (PTR_W)
  ) unconc_ptr_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .add_i    (back_xfer),  // Step after each delivered reply
    .ptr_o    (unconc_ptr)
  );

  // ########################################
  // Concentrate and unconcentrate
  // ########################################

  assign fwd_v_o     = req_v_i[conc_ptr];
  assign fwd_data_o  = req_data_i[conc_ptr];
  assign back_yumi_o = rsp_yumi_i[unconc_ptr];

  // One-hot steering of the two strobes
  always_comb
  begin
    req_yumi_o             = '0;
    rsp_v_o                = '0;
    req_yumi_o[conc_ptr]   = fwd_yumi_i;
    rsp_v_o[unconc_ptr]    = back_v_i;
  end

  for (genvar c = 0; c < NUM_CLIENTS; c++)
  begin : g_rsp_data
    assign rsp_data_o[c] = back_data_i; // Qualified by rsp_v_o
  end

endmodule

/* source/circular_ptr.sv */
module circular_ptr
#(
  parameter int SLOTS = link_pkg::NUM_CLIENTS_DEF,
  parameter int PTR_W = (SLOTS > 1) ? $clog2(SLOTS) : 1
)
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             add_i,
  output logic [PTR_W-1:0] ptr_o
);

  // Explicit wrap so a non power of two slot count never runs past the end
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(SLOTS - 1);

  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] ptr_d;

  always_comb
  begin
    ptr_d = ptr_q;
    if (add_i)
    begin
      if (ptr_q == LAST_SLOT)
      begin
        ptr_d = '0; // Wrap to first slot
      end
      else
      begin
        ptr_d = ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ptr_q <= '0;
    end
    else
    begin
      ptr_q <= ptr_d;
    end
  end

  assign ptr_o = ptr_q;

endmodule

/* source/link_pkg.sv */
package link_pkg;

  // ########################################
  // Default geometry
  // ########################################

  localparam int DATA_WIDTH_DEF     = 16;
  localparam int NUM_CLIENTS_DEF    = 4;
  localparam int SERVICE_CYCLES_DEF = 3; // Idle cycles inside the node

  // ########################################
  // Echo transform
  // ########################################

  // Truncated or zero-extended to the data width at the point of use
  localparam logic [15:0] REPLY_KEY = 16'h5a3c;

  // ########################################
  // Echo node FSM
  // ########################################

  typedef enum logic [1:0]
  {
    IDLE  = 2'd0, // Ready to take a word
    WAIT  = 2'd1, // Service delay
    REPLY = 2'd2  // Holding the reply
  } node_state_e;

endpackage
